//--- Bender.yml
package:
  name: vec_seq_top

sources:
  - hdl/vec_pkg.sv
  - hdl/vec_sequencer.sv
  - hdl/vec_lane.sv
  - hdl/vec_ldst_unit.sv
  - hdl/vec_seq_top.sv
  - target: test
    files:
      - dv/tb_vec_seq_top.sv

//--- dv/tb_vec_seq_top.sv
/*
 * Testbench for the vector sequencer subsystem
 * Sends random, dependent and back-to-back vector instructions, predicts
 * ids, hazard masks and memory responses with a reference model and
 * compares them with what the DUT reports
 */
module tb_vec_seq_top import vec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam time         ClkPeriod      = 100;
  localparam int unsigned NumInsn        = 56;
  localparam int unsigned WatchdogCycles = NumInsn * 300 + 64;

  logic    clk_i;
  logic    rst_ni;
  logic    req_valid_i;
  vec_op_e req_op_i;
  vreg_t   req_vs1_i;
  logic    req_use_vs1_i;
  vreg_t   req_vs2_i;
  logic    req_use_vs2_i;
  vreg_t   req_vd_i;
  logic    req_use_vd_i;
  vlen_t   req_vl_i;
  addr_t   req_addr_i;
  logic    req_ready_o;
  logic    resp_valid_o;
  logic    resp_error_o;
  logic    idle_o;
  logic    issue_valid_o;
  vid_t    issue_id_o;

  vec_seq_top vec_seq_top_inst (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////

  // Serial numbers of the last reader and writer of each register
  int        rd_sn [NrVRegs];
  int        wr_sn [NrVRegs];
  vid_t      id_of [NumInsn];
  logic      alive [NumInsn];
  int        dep_of [NumInsn];
  int        n_acc;
  logic      chk_issue;
  vid_t      exp_id;
  vid_mask_t exp_haz;
  logic      mem_pend;
  logic      exp_err;
  int        err_count;
  int        check_count;
  logic [31:0] lcg_state;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic vid_mask_t live_mask(int sn);
    if (sn < 0) begin
      return '0;
    end
    if (!alive[sn]) begin
      return '0;
    end
    return vid_mask_t'(1) << id_of[sn];
  endfunction

  function automatic vid_mask_t model_running();
    vid_mask_t m;
    m = '0;
    for (int s = 0; s < n_acc; s++) begin
      m |= live_mask(s);
    end
    return m;
  endfunction

  // Lowest id the model does not hold as running
  function automatic vid_t lowest_free(vid_mask_t running);
    for (int i = 0; i < NrVInsn; i++) begin
      if (!running[i]) begin
        return vid_t'(i);
      end
    end
    return '0;
  endfunction

  // RAW on sources, WAR and WAW on the destination
  function automatic vid_mask_t ref_hazard(vreg_t vs1, logic use1, vreg_t vs2, logic use2,
                                           vreg_t vd, logic use_d);
    vid_mask_t h;
    h = '0;
    if (use1) h |= live_mask(wr_sn[vs1]);
    if (use2) h |= live_mask(wr_sn[vs2]);
    if (use_d) begin
      h |= live_mask(rd_sn[vd]);
      h |= live_mask(wr_sn[vd]);
    end
    return h;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // All PEs idle means every instruction except the one on the broadcast has retired
  task automatic retire_except(input int keep);
    for (int s = 0; s < n_acc; s++) begin
      if (alive[s] && s != keep) begin
        alive[s] = 1'b0;
      end
    end
  endtask

  // A consumer may leave the running set only after its producer has left it
  task automatic check_order(input vid_mask_t running);
    int p;
    for (int s = 0; s < n_acc; s++) begin
      p = dep_of[s];
      if (alive[s] && p >= 0) begin
        if (alive[p] && !running[id_of[s]] && running[id_of[p]]) begin
          note_failure("consumer retired while its producer was still running");
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    vid_mask_t run_mask;
    int        sn;
    if (rst_ni) begin
      // Broadcast that follows the last transfer
      if (chk_issue) begin
        chk_issue = 1'b0;
        check_eq(issue_valid_o, 1'b1, "issue_valid_o after transfer");
        check_eq(issue_id_o, exp_id, "issue_id_o");
        check_eq(vec_seq_top_inst.pe_hazard, exp_haz, "hazard mask");
      end
      if (issue_valid_o && idle_o) begin
        note_failure("idle_o is high while an instruction is being issued");
      end
      check_order(vec_seq_top_inst.vinsn_running);
      if (idle_o) begin
        retire_except(-1);
      end
      if (resp_valid_o) begin
        if (!mem_pend) begin
          note_failure("memory response without a pending load or store");
        end else begin
          check_eq(resp_error_o, exp_err, "resp_error_o");
        end
        mem_pend = 1'b0;
      end
      run_mask = model_running();
      if (req_ready_o && (mem_pend || run_mask == '1)) begin
        note_failure("req_ready_o is high while the sequencer should back-pressure");
      end
      if (req_valid_i && req_ready_o) begin
        if (n_acc >= NumInsn) begin
          note_failure("more transfers than instructions sent");
        end else begin
          retire_except(issue_valid_o ? n_acc - 1 : -1);
          sn          = n_acc;
          id_of[sn]   = lowest_free(model_running());
          exp_id      = id_of[sn];
          exp_haz     = ref_hazard(req_vs1_i, req_use_vs1_i, req_vs2_i, req_use_vs2_i,
                                   req_vd_i, req_use_vd_i);
          dep_of[sn]  = -1;
          if (req_use_vs1_i && live_mask(wr_sn[req_vs1_i]) != '0) dep_of[sn] = wr_sn[req_vs1_i];
          if (req_use_vs2_i && live_mask(wr_sn[req_vs2_i]) != '0) dep_of[sn] = wr_sn[req_vs2_i];
          if (req_use_vd_i) wr_sn[req_vd_i] = sn;
          if (req_use_vs1_i) rd_sn[req_vs1_i] = sn;
          if (req_use_vs2_i) rd_sn[req_vs2_i] = sn;
          alive[sn]   = 1'b1;
          n_acc++;
          chk_issue   = 1'b1;
          if (req_op_i == VLE || req_op_i == VSE) begin
            mem_pend = 1'b1;
            exp_err  = (req_addr_i[1:0] != 2'b00);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_insn(input vec_op_e op, input vreg_t vs1, input logic use1,
                           input vreg_t vs2, input logic use2, input vreg_t vd,
                           input logic use_d, input vlen_t vl, input addr_t addr);
    req_valid_i   = 1'b1;
    req_op_i      = op;
    req_vs1_i     = vs1;
    req_use_vs1_i = use1;
    req_vs2_i     = vs2;
    req_use_vs2_i = use2;
    req_vd_i      = vd;
    req_use_vd_i  = use_d;
    req_vl_i      = vl;
    req_addr_i    = addr;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_random();
    logic [31:0] r_ctl;
    logic [31:0] r_len;
    logic [31:0] r_adr;
    addr_t       addr;
    r_ctl = lcg_next();
    r_len = lcg_next();
    r_adr = lcg_next();
    // Roughly one address in four gets random low bits
    addr  = {r_adr[31:2], 2'b00} |
            ((r_adr[21:20] == 2'b00) ? addr_t'(r_adr[17:16]) : addr_t'(0));
    send_insn(vec_op_e'(r_ctl[17:16]), vreg_t'(r_ctl[20:18]), r_ctl[24],
              vreg_t'(r_ctl[23:21]), r_ctl[25], vreg_t'(r_ctl[28:26]), r_ctl[29],
              vlen_t'(r_len[21:16]), addr);
    repeat (r_ctl[31:30]) @(negedge clk_i);
  endtask

  task automatic wait_idle();
    while (!idle_o) @(negedge clk_i);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = VADD;
    req_vs1_i     = '0;
    req_use_vs1_i = 1'b0;
    req_vs2_i     = '0;
    req_use_vs2_i = 1'b0;
    req_vd_i      = '0;
    req_use_vd_i  = 1'b0;
    req_vl_i      = '0;
    req_addr_i    = '0;
    lcg_state     = 32'd92;
    n_acc         = 0;
    chk_issue     = 1'b0;
    mem_pend      = 1'b0;
    exp_err       = 1'b0;
    err_count     = 0;
    check_count   = 0;
    for (int v = 0; v < NrVRegs; v++) begin
      rd_sn[v] = -1;
      wr_sn[v] = -1;
    end
    for (int s = 0; s < NumInsn; s++) begin
      alive[s]  = 1'b0;
      dep_of[s] = -1;
    end

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_eq(idle_o, 1'b1, "idle_o after reset");
    check_eq(req_ready_o, 1'b1, "req_ready_o after reset");
    check_eq(resp_valid_o, 1'b0, "resp_valid_o after reset");
    check_eq(issue_valid_o, 1'b0, "issue_valid_o after reset");
    @(negedge clk_i);

    // Random mix over a small register set
    for (int i = 0; i < 40; i++) begin
      send_random();
    end

    // Long producer followed at once by a short consumer
    for (int p = 0; p < 4; p++) begin
      wait_idle();
      send_insn(VMUL, '0, 1'b0, '0, 1'b0, vreg_t'(16 + p), 1'b1, 8'd200, '0);
      send_insn(VADD, vreg_t'(16 + p), 1'b1, vreg_t'(20), 1'b0, vreg_t'(24 + p), 1'b1,
                8'd2, '0);
    end

    // Burst of long independent ops, then a misaligned load and a store of its result
    wait_idle();
    for (int b = 0; b < 6; b++) begin
      send_insn(VMUL, '0, 1'b0, '0, 1'b0, vreg_t'(8 + b), 1'b1, 8'd180, '0);
    end
    send_insn(VLE, '0, 1'b0, '0, 1'b0, vreg_t'(14), 1'b1, 8'd40, 32'h0000_1002);
    send_insn(VSE, vreg_t'(14), 1'b1, '0, 1'b0, '0, 1'b0, 8'd30, 32'h0000_2000);

    // Drain and make sure the subsystem stays idle
    @(posedge clk_i);
    while (!idle_o) @(posedge clk_i);
    repeat (20) begin
      @(posedge clk_i);
      if (!idle_o) begin
        note_failure("idle_o dropped while no request was valid");
      end
    end
    if (mem_pend) begin
      note_failure("a memory instruction never received its response");
    end
    check_eq(n_acc, NumInsn, "number of transfers");

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- hdl/vec_lane.sv
/*
 * Arithmetic lane
 * Takes lane ops from the broadcast, waits until its hazards retire, then
 * executes for its share of the vector length and pulses done
 */
module vec_lane import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      pe_req_valid_i,
  input  logic      all_ready_i,
  input  vid_t      pe_req_id_i,
  input  vec_op_e   pe_req_op_i,
  input  vlen_t     pe_req_vl_i,
  input  vid_mask_t pe_hazard_i,
  input  vid_mask_t vinsn_running_i,
  output logic      pe_ready_o,
  output vid_mask_t pe_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    HAZARD,
    EXEC
  } lane_state_e;

  lane_state_e state_d, state_q;
  vlen_t       cnt_d, cnt_q;
  vid_t        id_q;
  vid_mask_t   hazard_q;
  logic        take;
  logic        clear;
  logic        last;

  assign take  = pe_req_valid_i && all_ready_i && is_lane_op(pe_req_op_i);
  assign clear = (hazard_q & vinsn_running_i) == '0;
  assign last  = (state_q == EXEC) && (cnt_q == vlen_t'(1));

  assign pe_ready_o = (state_q == IDLE);
  assign pe_done_o  = last ? vid_onehot(id_q) : '0;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      IDLE: begin
        if (take) begin
          state_d = HAZARD;
          cnt_d   = lane_cycles(pe_req_vl_i);
        end
      end
      HAZARD: begin
        if (clear) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (last) begin
          state_d = IDLE;
        end else begin
          cnt_d = cnt_q - vlen_t'(1);
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && state_q == IDLE) begin
      id_q     <= pe_req_id_i;
      hazard_q <= pe_hazard_i;
    end
  end

  // A done pulse names one id that the sequencer still counts as running
  a_done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_done_o != '0 |-> $onehot(pe_done_o) && ((pe_done_o & vinsn_running_i) != '0));

endmodule

//--- hdl/vec_ldst_unit.sv
/*
 * Load/store unit
 * Checks the base address for 4-byte alignment over two cycles and
 * acknowledges it to the sequencer, then waits out hazards and runs the
 * transfer for vl cycles, or none when the address was misaligned
 */
module vec_ldst_unit import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      pe_req_valid_i,
  input  logic      all_ready_i,
  input  vid_t      pe_req_id_i,
  input  vec_op_e   pe_req_op_i,
  input  vlen_t     pe_req_vl_i,
  input  addr_t     pe_req_addr_i,
  input  vid_mask_t pe_hazard_i,
  input  vid_mask_t vinsn_running_i,
  output logic      pe_ready_o,
  output vid_mask_t pe_done_o,
  output logic      addr_ack_o,
  output logic      addr_error_o
);

  typedef enum logic [1:0] {
    IDLE,
    TRANSLATE,
    HAZARD,
    XFER
  } ldst_state_e;

  ldst_state_e state_d, state_q;
  vlen_t       cnt_d, cnt_q;
  logic        tr_d, tr_q;
  vid_t        id_q;
  vid_mask_t   hazard_q;
  logic        err_q;
  logic        take;
  logic        clear;
  logic        done;

  assign take  = pe_req_valid_i && all_ready_i && is_mem(pe_req_op_i);
  assign clear = (hazard_q & vinsn_running_i) == '0;

  // Zero-length or failed transfers finish as soon as the hazards clear
  assign done = ((state_q == HAZARD) && clear && (cnt_q == '0)) ||
                ((state_q == XFER) && (cnt_q == vlen_t'(1)));

  assign pe_ready_o   = (state_q == IDLE);
  assign pe_done_o    = done ? vid_onehot(id_q) : '0;
  // Second translation cycle
  assign addr_ack_o   = (state_q == TRANSLATE) && tr_q;
  assign addr_error_o = addr_ack_o && err_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    tr_d    = tr_q;
    unique case (state_q)
      IDLE: begin
        if (take) begin
          state_d = TRANSLATE;
          tr_d    = 1'b0;
          cnt_d   = (pe_req_addr_i[1:0] != 2'b00) ? '0 : pe_req_vl_i;
        end
      end
      TRANSLATE: begin
        tr_d = 1'b1;
        if (tr_q) begin
          state_d = HAZARD;
        end
      end
      HAZARD: begin
        if (clear) begin
          state_d = (cnt_q == '0) ? IDLE : XFER;
        end
      end
      XFER: begin
        if (done) begin
          state_d = IDLE;
        end else begin
          cnt_d = cnt_q - vlen_t'(1);
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      tr_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      tr_q    <= tr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && state_q == IDLE) begin
      id_q     <= pe_req_id_i;
      hazard_q <= pe_hazard_i;
      err_q    <= (pe_req_addr_i[1:0] != 2'b00);
    end
  end

endmodule

//--- hdl/vec_pkg.sv
/*
 * Vector sequencer package
 * Sizes, meaningful widths, the opcode encoding and small helpers shared by
 * the sequencer, the arithmetic lanes and the load/store unit
 */
package vec_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NrLanes = 2;
  // Lanes first, then the load/store unit at the last index
  localparam int unsigned NrPEs   = NrLanes + 1;
  localparam int unsigned LdstIdx = NrPEs - 1;
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned NrVRegs = 32;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [NrVInsn-1:0]         vid_mask_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [7:0]                 vlen_t;
  typedef logic [31:0]                addr_t;

  typedef enum logic [1:0] {
    VADD = 2'd0,
    VMUL = 2'd1,
    VLE  = 2'd2,
    VSE  = 2'd3
  } vec_op_e;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic is_mem(vec_op_e op);
    return (op == VLE) || (op == VSE);
  endfunction

  function automatic logic is_lane_op(vec_op_e op);
    return (op == VADD) || (op == VMUL);
  endfunction

  function automatic vid_mask_t vid_onehot(vid_t id);
    return vid_mask_t'(1) << id;
  endfunction

  // Cycles one lane spends on an instruction, never less than one
  function automatic vlen_t lane_cycles(vlen_t vl);
    logic [8:0] sum;
    sum = {1'b0, vl} + 9'(NrLanes - 1);
    if (vl == '0) begin
      return vlen_t'(1);
    end
    return vlen_t'(sum / NrLanes);
  endfunction

endpackage

//--- hdl/vec_seq_top.sv
/*
 * Vector sequencer subsystem
 * Sequencer with its arithmetic lanes and the load/store unit
 */
module vec_seq_top import vec_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    req_valid_i,
  input  vec_op_e req_op_i,
  input  vreg_t   req_vs1_i,
  input  logic    req_use_vs1_i,
  input  vreg_t   req_vs2_i,
  input  logic    req_use_vs2_i,
  input  vreg_t   req_vd_i,
  input  logic    req_use_vd_i,
  input  vlen_t   req_vl_i,
  input  addr_t   req_addr_i,
  output logic    req_ready_o,
  output logic    resp_valid_o,
  output logic    resp_error_o,
  output logic    idle_o,
  output logic    issue_valid_o,
  output vid_t    issue_id_o
);

  logic      [NrPEs-1:0] pe_ready;
  vid_mask_t [NrPEs-1:0] pe_done;
  logic                  all_ready;
  logic                  pe_req_valid;
  vid_t                  pe_req_id;
  vec_op_e               pe_req_op;
  vlen_t                 pe_req_vl;
  addr_t                 pe_req_addr;
  vid_mask_t             pe_hazard;
  vid_mask_t             vinsn_running;
  logic                  addr_ack;
  logic                  addr_error;

  // A broadcast is taken only when every PE can see it
  assign all_ready     = &pe_ready;
  assign issue_valid_o = pe_req_valid;
  assign issue_id_o    = pe_req_id;

  vec_sequencer vec_sequencer_inst (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vs1_i, .req_use_vs1_i, .req_vs2_i, .req_use_vs2_i,
    .req_vd_i, .req_use_vd_i, .req_vl_i, .req_addr_i,
    .req_ready_o, .resp_valid_o, .resp_error_o, .idle_o,
    .pe_ready_i      (pe_ready),
    .pe_done_i       (pe_done),
    .addr_ack_i      (addr_ack),
    .addr_error_i    (addr_error),
    .pe_req_valid_o  (pe_req_valid),
    .pe_req_id_o     (pe_req_id),
    .pe_req_op_o     (pe_req_op),
    .pe_req_vl_o     (pe_req_vl),
    .pe_req_addr_o   (pe_req_addr),
    .pe_hazard_o     (pe_hazard),
    .vinsn_running_o (vinsn_running)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    vec_lane vec_lane_inst (
      .clk_i, .rst_ni,
      .pe_req_valid_i  (pe_req_valid),
      .all_ready_i     (all_ready),
      .pe_req_id_i     (pe_req_id),
      .pe_req_op_i     (pe_req_op),
      .pe_req_vl_i     (pe_req_vl),
      .pe_hazard_i     (pe_hazard),
      .vinsn_running_i (vinsn_running),
      .pe_ready_o      (pe_ready[l]),
      .pe_done_o       (pe_done[l])
    );
  end

  vec_ldst_unit vec_ldst_unit_inst (
    .clk_i, .rst_ni,
    .pe_req_valid_i  (pe_req_valid),
    .all_ready_i     (all_ready),
    .pe_req_id_i     (pe_req_id),
    .pe_req_op_i     (pe_req_op),
    .pe_req_vl_i     (pe_req_vl),
    .pe_req_addr_i   (pe_req_addr),
    .pe_hazard_i     (pe_hazard),
    .vinsn_running_i (vinsn_running),
    .pe_ready_o      (pe_ready[LdstIdx]),
    .pe_done_o       (pe_done[LdstIdx]),
    .addr_ack_o      (addr_ack),
    .addr_error_o    (addr_error)
  );

endmodule

//--- hdl/vec_sequencer.sv
/*
 * Vector instruction sequencer
 * Hands out instruction ids, tracks which running instruction reads and
 * writes each vector register, attaches hazard masks and broadcasts each
 * request to the processing elements. Memory ops are committed on the
 * address acknowledge from the load/store unit
 */
module vec_sequencer import vec_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Dispatcher request
  input  logic                  req_valid_i,
  input  vec_op_e               req_op_i,
  input  vreg_t                 req_vs1_i,
  input  logic                  req_use_vs1_i,
  input  vreg_t                 req_vs2_i,
  input  logic                  req_use_vs2_i,
  input  vreg_t                 req_vd_i,
  input  logic                  req_use_vd_i,
  input  vlen_t                 req_vl_i,
  input  addr_t                 req_addr_i,
  output logic                  req_ready_o,
  output logic                  resp_valid_o,
  output logic                  resp_error_o,
  output logic                  idle_o,
  // Processing elements
  input  logic      [NrPEs-1:0] pe_ready_i,
  input  vid_mask_t [NrPEs-1:0] pe_done_i,
  input  logic                  addr_ack_i,
  input  logic                  addr_error_i,
  output logic                  pe_req_valid_o,
  output vid_t                  pe_req_id_o,
  output vec_op_e               pe_req_op_o,
  output vlen_t                 pe_req_vl_o,
  output addr_t                 pe_req_addr_o,
  output vid_mask_t             pe_hazard_o,
  output vid_mask_t             vinsn_running_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } seq_state_e;

  seq_state_e state_d, state_q;

  //////////////////////////////////////////////////
  // Running instructions
  //////////////////////////////////////////////////

  vid_mask_t [NrPEs-1:0] pe_running_d, pe_running_q, pe_kept;
  vid_mask_t             running, running_kept;
  vid_t                  free_id;
  logic                  full;

  always_comb begin
    running      = '0;
    running_kept = '0;
    for (int pe = 0; pe < NrPEs; pe++) begin
      pe_kept[pe]   = pe_running_q[pe] & ~pe_done_i[pe];
      running      |= pe_running_q[pe];
      running_kept |= pe_kept[pe];
    end
  end

  // Lowest free id; the descending scan leaves the lowest one last
  always_comb begin
    free_id = '0;
    full    = 1'b1;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running[i]) begin
        free_id = vid_t'(i);
        full    = 1'b0;
      end
    end
  end

  assign idle_o          = (running == '0);
  assign vinsn_running_o = running;

  //////////////////////////////////////////////////
  // Register access lists and issue
  //////////////////////////////////////////////////

  vid_t                 rd_vid_d [NrVRegs];
  vid_t                 rd_vid_q [NrVRegs];
  vid_t                 wr_vid_d [NrVRegs];
  vid_t                 wr_vid_q [NrVRegs];
  logic [NrVRegs-1:0]   rd_valid_d, rd_valid_q;
  logic [NrVRegs-1:0]   wr_valid_d, wr_valid_q;

  logic      pe_req_valid_d;
  vid_t      pe_req_id_d;
  vec_op_e   pe_req_op_d;
  vlen_t     pe_req_vl_d;
  addr_t     pe_req_addr_d;
  vid_mask_t pe_hazard_d;
  vid_mask_t hazard_new;

  logic all_ready;
  logic pending;
  logic accept;

  assign all_ready   = &pe_ready_i;
  // Broadcast that no PE has taken yet
  assign pending     = pe_req_valid_o && !all_ready;
  assign req_ready_o = (state_q == IDLE) && !pending && all_ready && !full;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    state_d      = state_q;
    pe_running_d = pe_kept;
    rd_vid_d     = rd_vid_q;
    wr_vid_d     = wr_vid_q;
    resp_valid_o = 1'b0;
    resp_error_o = 1'b0;

    // Forget accesses of retired instructions
    for (int v = 0; v < NrVRegs; v++) begin
      rd_valid_d[v] = rd_valid_q[v] && running_kept[rd_vid_q[v]];
      wr_valid_d[v] = wr_valid_q[v] && running_kept[wr_vid_q[v]];
    end

    // Hold the broadcast, dropping hazards that retired
    pe_req_valid_d = pending;
    pe_req_id_d    = pe_req_id_o;
    pe_req_op_d    = pe_req_op_o;
    pe_req_vl_d    = pe_req_vl_o;
    pe_req_addr_d  = pe_req_addr_o;
    pe_hazard_d    = pe_hazard_o & running_kept;

    // RAW on the sources, WAR and WAW on the destination
    hazard_new = '0;
    if (req_use_vs1_i && wr_valid_d[req_vs1_i]) begin
      hazard_new[wr_vid_q[req_vs1_i]] = 1'b1;
    end
    if (req_use_vs2_i && wr_valid_d[req_vs2_i]) begin
      hazard_new[wr_vid_q[req_vs2_i]] = 1'b1;
    end
    if (req_use_vd_i && rd_valid_d[req_vd_i]) begin
      hazard_new[rd_vid_q[req_vd_i]] = 1'b1;
    end
    if (req_use_vd_i && wr_valid_d[req_vd_i]) begin
      hazard_new[wr_vid_q[req_vd_i]] = 1'b1;
    end

    if (accept) begin
      pe_req_valid_d = 1'b1;
      pe_req_id_d    = free_id;
      pe_req_op_d    = req_op_i;
      pe_req_vl_d    = req_vl_i;
      pe_req_addr_d  = req_addr_i;
      pe_hazard_d    = hazard_new;

      // Lane ops run on every lane at once
      if (is_lane_op(req_op_i)) begin
        for (int l = 0; l < NrLanes; l++) begin
          pe_running_d[l][free_id] = 1'b1;
        end
      end else begin
        pe_running_d[LdstIdx][free_id] = 1'b1;
      end

      if (req_use_vd_i) begin
        wr_vid_d[req_vd_i]   = free_id;
        wr_valid_d[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        rd_vid_d[req_vs1_i]   = free_id;
        rd_valid_d[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_vid_d[req_vs2_i]   = free_id;
        rd_valid_d[req_vs2_i] = 1'b1;
      end

      if (is_mem(req_op_i)) begin
        state_d = WAIT;
      end
    end

    // Commit the memory op once its address is checked
    if (state_q == WAIT && addr_ack_i) begin
      resp_valid_o = 1'b1;
      resp_error_o = addr_error_i;
      state_d      = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_running_q   <= '0;
      rd_valid_q     <= '0;
      wr_valid_q     <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_running_q   <= pe_running_d;
      rd_valid_q     <= rd_valid_d;
      wr_valid_q     <= wr_valid_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_vid_q      <= rd_vid_d;
    wr_vid_q      <= wr_vid_d;
    pe_req_id_o   <= pe_req_id_d;
    pe_req_op_o   <= pe_req_op_d;
    pe_req_vl_o   <= pe_req_vl_d;
    pe_req_addr_o <= pe_req_addr_d;
    pe_hazard_o   <= pe_hazard_d;
  end

  // An untaken broadcast stays up with the same id
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending |=> pe_req_valid_o && $stable(pe_req_id_o));

  // The id handed out was free when the request was accepted
  a_fresh_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> pe_req_valid_o && (($past(running) & vid_onehot(pe_req_id_o)) == '0));

endmodule

//--- vec_seq_top.f
hdl/vec_pkg.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_ldst_unit.sv
hdl/vec_seq_top.sv
dv/tb_vec_seq_top.sv
